// File: files.f
roadf_pkg.sv
roadf_dl_fsm.sv
roadf_dl_counter.sv
roadf_region_map.sv
roadf_rom_store.sv
roadf_loader_top.sv
roadf_loader_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := roadf_loader_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Done: no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: roadf_loader_tb.sv
// Testbench for the ROM download path
// Streams two downloads through the loader top level, then reads the store back
module roadf_loader_tb;
    timeunit 1ns;
    timeprecision 1ns;

    localparam int ADDR_W    = 10;
    localparam int HDR_LEN   = 8;
    localparam int SCR_START = 256;
    localparam int OBJ_START = 512;
    localparam int PCM_START = 768;
    localparam int MEM_SIZE  = 2 ** ADDR_W;
    localparam int EXCESS    = 16;
    localparam int N_EDGE    = 6;
    localparam int N_TBL     = 16;
    localparam int N_READS   = 2 * N_TBL + EXCESS;
    localparam int LIMIT     = (2 * HDR_LEN + 2 * MEM_SIZE + EXCESS + N_READS) * 4 + 100;

    // Test ids
    localparam int T_RESET    = 0;
    localparam int T_VARIANT  = 1;
    localparam int T_MAIN_PCM = 2;
    localparam int T_SCR      = 3;
    localparam int T_OBJ      = 4;
    localparam int T_DONE_OVR = 5;

    logic              clk;
    logic              rst;
    logic              dl_active;
    logic              byte_wr;
    roadf_pkg::byte_t  byte_data;
    logic [ADDR_W-1:0] rd_addr;
    roadf_pkg::byte_t  rd_data;
    logic              is_hyper;
    logic              dl_done;
    logic              overrun;

    // Stimulus and expected values, one entry per checked body byte
    int                tbl_addr [N_TBL];
    roadf_pkg::byte_t  tbl_data [N_TBL];
    logic [ADDR_W-1:0] tbl_raddr [N_TBL];
    int                edge_addr [N_EDGE] = '{255, 256, 511, 512, 767, 768};
    roadf_pkg::byte_t  edge_data [N_EDGE] = '{8'h3c, 8'hc3, 8'h5a, 8'ha5, 8'h0f, 8'hf0};

    // Full body image streamed to the DUT
    roadf_pkg::byte_t  body_img [MEM_SIZE];
    bit                used [MEM_SIZE];
    int                test_err [6];
    int                errors       = 0;
    int                tests_failed = 0;
    int                cycles       = 0;
    integer            seed         = 8200;

    roadf_loader_top #(
        .ADDR_W    (ADDR_W),
        .HDR_LEN   (HDR_LEN),
        .SCR_START (SCR_START),
        .OBJ_START (OBJ_START),
        .PCM_START (PCM_START)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .dl_active (dl_active),
        .byte_wr   (byte_wr),
        .byte_data (byte_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .is_hyper  (is_hyper),
        .dl_done   (dl_done),
        .overrun   (overrun)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    function automatic roadf_pkg::region_e region_of(input int a);
        if (a >= PCM_START) begin
            return roadf_pkg::REGION_PCM;
        end else if (a >= OBJ_START) begin
            return roadf_pkg::REGION_OBJ;
        end else if (a >= SCR_START) begin
            return roadf_pkg::REGION_SCR;
        end
        return roadf_pkg::REGION_MAIN;
    endfunction

    // Expected store address, bit by bit from the reordering rule
    function automatic logic [ADDR_W-1:0] store_addr_of(input int a);
        logic [ADDR_W-1:0] r;
        r = a[ADDR_W-1:0];
        if (region_of(a) == roadf_pkg::REGION_SCR) begin
            r[3] = a[2];
            r[2] = a[1];
            r[1] = a[0];
            r[0] = ~a[3];
        end else if (region_of(a) == roadf_pkg::REGION_OBJ) begin
            r[4] = a[2];
            r[3] = a[1];
            r[2] = a[0];
            r[1] = ~a[4];
            r[0] = ~a[3];
        end
        return r;
    endfunction

    function automatic int test_for(input int a);
        case (region_of(a))
            roadf_pkg::REGION_SCR: return T_SCR;
            roadf_pkg::REGION_OBJ: return T_OBJ;
            default:               return T_MAIN_PCM;
        endcase
    endfunction

    // Bytes past the store end are inverted so a wrap would show up
    function automatic roadf_pkg::byte_t body_byte(input int i);
        if (i < MEM_SIZE) begin
            return body_img[i];
        end
        return ~body_img[i - MEM_SIZE];
    endfunction

    task automatic check_val(input string sig, input logic [31:0] got,
                             input logic [31:0] exp, input int id);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", sig, got, exp);
            errors++;
            test_err[id]++;
        end
    endtask

    task automatic report_test(input int id, input string name);
        if (test_err[id] == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, test_err[id]);
            tests_failed++;
        end
    endtask

    task automatic build_table();
        int a;
        for (a = 0; a < MEM_SIZE; a++) begin
            body_img[a] = 8'(a ^ (a >> 3) ^ 'h5a);
        end
        for (int i = 0; i < N_EDGE; i++) begin
            tbl_addr[i] = edge_addr[i];
            tbl_data[i] = edge_data[i];
            used[edge_addr[i]] = 1'b1;
        end
        // Random entries at distinct addresses
        for (int i = N_EDGE; i < N_TBL; i++) begin
            a = $random(seed) & (MEM_SIZE - 1);
            while (used[a]) begin
                a = $random(seed) & (MEM_SIZE - 1);
            end
            used[a] = 1'b1;
            tbl_addr[i] = a;
            tbl_data[i] = 8'($random(seed));
        end
        for (int i = 0; i < N_TBL; i++) begin
            tbl_raddr[i] = store_addr_of(tbl_addr[i]);
            body_img[tbl_addr[i]] = tbl_data[i];
        end
    endtask

    task automatic download(input roadf_pkg::byte_t hdr0, input int body_len,
                            input logic exp_hyper, input logic exp_overrun);
        int i;
        dl_active = 1'b1;
        @(negedge clk);
        for (i = 0; i < HDR_LEN; i++) begin
            byte_wr   = 1'b1;
            byte_data = (i == 0) ? hdr0 : 8'(8'ha0 + i);
            @(negedge clk);
        end
        for (i = 0; i < body_len; i++) begin
            byte_wr   = 1'b1;
            byte_data = body_byte(i);
            if (i == 0) begin
                check_val("is_hyper", 32'(is_hyper), 32'(exp_hyper), T_VARIANT);
                check_val("dl_done", 32'(dl_done), 32'd0, T_DONE_OVR);
            end
            @(negedge clk);
        end
        byte_wr   = 1'b0;
        dl_active = 1'b0;
        while (!dl_done) begin
            @(negedge clk);
        end
        check_val("overrun", 32'(overrun), 32'(exp_overrun), T_DONE_OVR);
    endtask

    // Read data is sampled one cycle after the address
    task automatic read_check(input logic [ADDR_W-1:0] raddr, input roadf_pkg::byte_t exp,
                              input int id);
        rd_addr = raddr;
        @(negedge clk);
        check_val($sformatf("rd_data[%0h]", rd_addr), 32'(rd_data), 32'(exp), id);
    endtask

    task automatic readback(input int id);
        for (int i = 0; i < N_TBL; i++) begin
            if (id == T_DONE_OVR || test_for(tbl_addr[i]) == id) begin
                read_check(tbl_raddr[i], tbl_data[i], id);
            end
        end
    endtask

    initial begin
        rst       = 1'b1;
        dl_active = 1'b0;
        byte_wr   = 1'b0;
        byte_data = '0;
        rd_addr   = '0;
        for (int i = 0; i < 6; i++) begin
            test_err[i] = 0;
        end
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        check_val("is_hyper", 32'(is_hyper), 32'd0, T_RESET);
        check_val("dl_done", 32'(dl_done), 32'd0, T_RESET);
        check_val("overrun", 32'(overrun), 32'd0, T_RESET);
        report_test(T_RESET, "reset");

        // Hyper Sports header, body fills the store exactly
        download(8'h01, MEM_SIZE, 1'b1, 1'b0);
        readback(T_MAIN_PCM);
        report_test(T_MAIN_PCM, "main_pcm");
        readback(T_SCR);
        report_test(T_SCR, "scroll");
        readback(T_OBJ);
        report_test(T_OBJ, "object");

        // Road Fighter header, body runs past the store end
        download(8'hfe, MEM_SIZE + EXCESS, 1'b0, 1'b1);
        report_test(T_VARIANT, "variant");
        readback(T_DONE_OVR);
        for (int a = 0; a < EXCESS; a++) begin
            read_check(store_addr_of(a), body_img[a], T_DONE_OVR);
        end
        report_test(T_DONE_OVR, "done_overrun");

        $display("summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: roadf_loader_top.sv
// ROM download path top level
// Links sequencer, counter, region map and store and sets their parameters
module roadf_loader_top #(
    parameter int ADDR_W    = 10,
    parameter int HDR_LEN   = 8,
    parameter int SCR_START = 256,
    parameter int OBJ_START = 512,
    parameter int PCM_START = 768
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dl_active,
    input  logic              byte_wr,
    input  roadf_pkg::byte_t  byte_data,
    input  logic [ADDR_W-1:0] rd_addr,
    output roadf_pkg::byte_t  rd_data,
    output logic              is_hyper,
    output logic              dl_done,
    output logic              overrun
);

    logic                  hdr_phase;
    logic                  body_phase;
    logic                  hdr_last;
    logic                  is_first;
    roadf_pkg::load_addr_t body_addr;
    logic                  body_wr;
    logic                  store_we;
    logic [ADDR_W-1:0]     store_addr;
    roadf_pkg::byte_t      store_data;

    roadf_dl_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .dl_active  (dl_active),
        .byte_wr    (byte_wr),
        .byte_data  (byte_data),
        .hdr_last   (hdr_last),
        .is_first   (is_first),
        .hdr_phase  (hdr_phase),
        .body_phase (body_phase),
        .dl_done    (dl_done),
        .is_hyper   (is_hyper)
    );

    roadf_dl_counter #(
        .HDR_LEN (HDR_LEN),
        .ADDR_W  (ADDR_W)
    ) u_counter (
        .clk        (clk),
        .rst        (rst),
        .dl_active  (dl_active),
        .byte_wr    (byte_wr),
        .hdr_phase  (hdr_phase),
        .body_phase (body_phase),
        .hdr_last   (hdr_last),
        .is_first   (is_first),
        .body_addr  (body_addr),
        .body_wr    (body_wr),
        .overrun    (overrun)
    );

    roadf_region_map #(
        .ADDR_W    (ADDR_W),
        .SCR_START (SCR_START),
        .OBJ_START (OBJ_START),
        .PCM_START (PCM_START)
    ) u_region (
        .clk        (clk),
        .rst        (rst),
        .body_addr  (body_addr),
        .body_wr    (body_wr),
        .byte_data  (byte_data),
        .store_we   (store_we),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    roadf_rom_store #(
        .ADDR_W (ADDR_W)
    ) u_store (
        .clk     (clk),
        .we      (store_we),
        .waddr   (store_addr),
        .wdata   (store_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

// File: roadf_rom_store.sv
// Byte store for the downloaded ROM body
// One write port from the region map, one registered read port for the core
module roadf_rom_store #(
    parameter int ADDR_W = 10
) (
    input  logic              clk,
    input  logic              we,
    input  logic [ADDR_W-1:0] waddr,
    input  roadf_pkg::byte_t  wdata,
    input  logic [ADDR_W-1:0] rd_addr,
    output roadf_pkg::byte_t  rd_data
);

    localparam int DEPTH = 2 ** ADDR_W;

    roadf_pkg::byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read data valid one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Write address comes through the counter and region map registers
    a_waddr_known: assert property (
        @(posedge clk)
        we |-> !$isunknown(waddr)
    );

endmodule

// File: roadf_region_map.sv
// Region decode and graphics address reordering for body bytes
// Registers the translated write toward the ROM store
module roadf_region_map #(
    parameter int ADDR_W    = 10,
    parameter int SCR_START = 256,
    parameter int OBJ_START = 512,
    parameter int PCM_START = 768
) (
    input  logic                  clk,
    input  logic                  rst,
    input  roadf_pkg::load_addr_t body_addr,
    input  logic                  body_wr,
    input  roadf_pkg::byte_t      byte_data,
    output logic                  store_we,
    output logic [ADDR_W-1:0]     store_addr,
    output roadf_pkg::byte_t      store_data
);

    roadf_pkg::region_e    region;
    roadf_pkg::load_addr_t mapped;

    // Regions are contiguous, checked from the top down
    always_comb begin
        if (body_addr >= roadf_pkg::load_addr_t'(PCM_START)) begin
            region = roadf_pkg::REGION_PCM;
        end else if (body_addr >= roadf_pkg::load_addr_t'(OBJ_START)) begin
            region = roadf_pkg::REGION_OBJ;
        end else if (body_addr >= roadf_pkg::load_addr_t'(SCR_START)) begin
            region = roadf_pkg::REGION_SCR;
        end else begin
            region = roadf_pkg::REGION_MAIN;
        end
    end

    // Graphics ROMs are stored with their low address bits rotated so the
    // video fetch reads a whole tile row in sequence
    always_comb begin
        mapped = body_addr;
        case (region)
            roadf_pkg::REGION_SCR: begin
                mapped[3:0] = {body_addr[2:0], ~body_addr[3]};
            end
            roadf_pkg::REGION_OBJ: begin
                mapped[4:0] = {body_addr[2:0], ~body_addr[4], ~body_addr[3]};
            end
            default: begin
                // Main and PCM keep their load address
                mapped = body_addr;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            store_we <= 1'b0;
        end else begin
            store_we <= body_wr;
        end
    end

    // Payload only follows a valid strobe
    always_ff @(posedge clk) begin
        if (body_wr) begin
            store_addr <= mapped[ADDR_W-1:0];
            store_data <= byte_data;
        end
    end

endmodule

// File: roadf_dl_counter.sv
// Header byte counter and body load address generator
// Drops body strobes that fall outside the store and flags the overrun
module roadf_dl_counter #(
    parameter int HDR_LEN = 8,
    parameter int ADDR_W  = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dl_active,
    input  logic                  byte_wr,
    input  logic                  hdr_phase,
    input  logic                  body_phase,
    output logic                  hdr_last,
    output logic                  is_first,
    output roadf_pkg::load_addr_t body_addr,
    output logic                  body_wr,
    output logic                  overrun
);

    roadf_pkg::hdr_cnt_t hdr_cnt;
    logic                dl_active_q;
    logic                dl_start;
    logic                in_range;

    assign dl_start = dl_active & ~dl_active_q;
    // Upper bits beyond the store width must all be clear
    assign in_range = (body_addr >> ADDR_W) == '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            dl_active_q <= 1'b0;
            hdr_cnt     <= '0;
            body_addr   <= '0;
            overrun     <= 1'b0;
        end else begin
            dl_active_q <= dl_active;
            if (dl_start) begin
                hdr_cnt <= '0;
                overrun <= 1'b0;
            end else if (hdr_phase && byte_wr) begin
                hdr_cnt <= hdr_cnt + 1'b1;
            end
            if (!body_phase) begin
                body_addr <= '0;
            end else if (byte_wr && body_addr != '1) begin
                // Saturates so a long stream cannot wrap back into range
                body_addr <= body_addr + 1'b1;
            end
            if (body_phase && byte_wr && !in_range) begin
                overrun <= 1'b1;
            end
        end
    end

    assign is_first = hdr_phase && hdr_cnt == '0;
    assign hdr_last = hdr_phase && byte_wr && hdr_cnt == roadf_pkg::hdr_cnt_t'(HDR_LEN - 1);
    assign body_wr  = body_phase && byte_wr && in_range;

    // Body address only moves up while the body runs
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        body_phase && $past(body_phase) |-> body_addr >= $past(body_addr)
    );

endmodule

// File: roadf_dl_fsm.sv
// Download sequencer for the loader stream
// Steps through header and body phases and latches the board variant flag
module roadf_dl_fsm (
    input  logic               clk,
    input  logic               rst,
    input  logic               dl_active,
    input  logic               byte_wr,
    input  roadf_pkg::byte_t   byte_data,
    input  logic               hdr_last,
    input  logic               is_first,
    output logic               hdr_phase,
    output logic               body_phase,
    output logic               dl_done,
    output logic               is_hyper
);

    roadf_pkg::dl_state_e state;
    roadf_pkg::dl_state_e state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            roadf_pkg::DL_IDLE: begin
                if (dl_active) begin
                    state_nxt = roadf_pkg::DL_HEADER;
                end
            end
            roadf_pkg::DL_HEADER: begin
                // Loader gave up before the header was complete
                if (!dl_active) begin
                    state_nxt = roadf_pkg::DL_IDLE;
                end else if (hdr_last) begin
                    state_nxt = roadf_pkg::DL_BODY;
                end
            end
            roadf_pkg::DL_BODY: begin
                if (!dl_active) begin
                    state_nxt = roadf_pkg::DL_DONE;
                end
            end
            roadf_pkg::DL_DONE: begin
                // Held here until a new download starts
                if (dl_active) begin
                    state_nxt = roadf_pkg::DL_HEADER;
                end
            end
            default: begin
                state_nxt = roadf_pkg::DL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= roadf_pkg::DL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Bit 0 of header byte 0 selects Hyper Sports over Road Fighter
    always_ff @(posedge clk) begin
        if (rst) begin
            is_hyper <= 1'b0;
        end else if (byte_wr && is_first && state == roadf_pkg::DL_HEADER) begin
            is_hyper <= byte_data[0];
        end
    end

    assign hdr_phase  = (state == roadf_pkg::DL_HEADER);
    assign body_phase = (state == roadf_pkg::DL_BODY);
    assign dl_done    = (state == roadf_pkg::DL_DONE);

    // Counter must only flag the last header byte while the header is running
    a_hdr_last_in_header: assert property (
        @(posedge clk) disable iff (rst)
        hdr_last |-> state == roadf_pkg::DL_HEADER
    );

endmodule

// File: roadf_pkg.sv
// Shared types for the ROM download path
// Referenced by scoped name from the loader modules
package roadf_pkg;

    // One byte from the loader stream
    typedef logic [7:0] byte_t;

    // Header byte index, headers up to 16 bytes
    typedef logic [3:0] hdr_cnt_t;

    // Body load address, sized for the largest supported store
    typedef logic [15:0] load_addr_t;

    // Region that a body address falls in
    typedef enum logic [1:0] {
        REGION_MAIN = 2'd0,
        REGION_SCR  = 2'd1,
        REGION_OBJ  = 2'd2,
        REGION_PCM  = 2'd3
    } region_e;

    // Download sequencing
    typedef enum logic [1:0] {
        DL_IDLE   = 2'd0,
        DL_HEADER = 2'd1,
        DL_BODY   = 2'd2,
        DL_DONE   = 2'd3
    } dl_state_e;

endpackage
